// ==== common/id_config.svh ====
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// Datapath sizes
`define ID_NUM_REGS         32
`define ID_NB_DATA          32
`define ID_NB_REG           5
`define ID_NB_OPCODE        6

// Primary opcodes, bits 31:26
`define OP_RTYPE            6'b000000
`define OP_J                6'b000010
`define OP_JAL              6'b000011
`define OP_BEQ              6'b000100
`define OP_BNE              6'b000101
`define OP_ADDI             6'b001000
`define OP_SLTI             6'b001010
`define OP_ANDI             6'b001100
`define OP_ORI              6'b001101
`define OP_LUI              6'b001111
`define OP_LB               6'b100000
`define OP_LH               6'b100001
`define OP_LW               6'b100011
`define OP_SB               6'b101000
`define OP_SH               6'b101001
`define OP_SW               6'b101011
`define OP_HALT             6'b111111

// Function codes for R-type, bits 5:0
`define FN_JR               6'b001000
`define FN_JALR             6'b001001

`endif

// ==== common/id_pkg.sv ====
`include "id_config.svh"

package id_pkg;

    typedef logic [31:0]                inst_t;     // Raw instruction word
    typedef logic [31:0]                pc_t;
    typedef logic [`ID_NB_DATA-1:0]     data_t;     // Register value
    typedef logic [`ID_NB_REG-1:0]      reg_addr_t;
    typedef logic [`ID_NB_OPCODE-1:0]   opcode_t;
    typedef logic [`ID_NB_OPCODE-1:0]   funct_t;
    typedef logic [`ID_NB_OPCODE-1:0]   alu_op_t;   // Funct or opcode, decoded in EX

    typedef enum logic [0:0] {
        CU_RUN,
        CU_HALTED                                   // Sticky until reset
    } cu_state_t;

    // Control bundle handed to EX, MEM and WB
    typedef struct packed {
        logic       reg_dest;       // EX, rd instead of rt as target
        alu_op_t    alu_op;         // EX
        logic       alu_src;        // EX, immediate as operand B
        logic       mem_read;       // MEM
        logic       mem_write;      // MEM
        logic       branch;         // MEM
        logic       reg_write;      // WB
        logic       mem_to_reg;     // WB
        logic       jump;
        logic       jr_jalr;
        logic       byte_en;        // Access size
        logic       halfword_en;
        logic       word_en;
        logic       hlt;
    } ctrl_t;

    // Write-back port coming from WB
    typedef struct packed {
        logic       en;
        reg_addr_t  addr;
        data_t      data;
    } wb_t;

    // Operand bundle handed to EX
    typedef struct packed {
        data_t      data_a;         // Value of rs
        data_t      data_b;         // Value of rt
        data_t      immediate;      // Sign-extended imm16
        data_t      shamt;          // Zero-extended
        reg_addr_t  rt;
        reg_addr_t  rd;
        pc_t        pc;
        pc_t        jump_address;
    } operands_t;

endpackage

// ==== id_stage/register_bank.sv ====
`timescale 1ns/1ns
`include "id_config.svh"

module register_bank (
    input  logic                i_clock,
    input  logic                i_rst,
    input  id_pkg::wb_t         i_wb,
    input  id_pkg::reg_addr_t   i_read_a,
    input  id_pkg::reg_addr_t   i_read_b,
    output id_pkg::data_t       o_data_a,
    output id_pkg::data_t       o_data_b
);

    id_pkg::data_t regs [`ID_NUM_REGS];

    // One read port: zero register, then same-cycle bypass, then the array
    function automatic id_pkg::data_t read_port(input id_pkg::reg_addr_t addr);
        id_pkg::data_t value;
        if (addr == '0) begin
            value = '0;
        end else if (i_wb.en && (i_wb.addr == addr)) begin
            value = i_wb.data;                  // Write-back forwarded
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < `ID_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.en && (i_wb.addr != '0)) begin
            regs[i_wb.addr] <= i_wb.data;       // r0 never written
        end
    end

    always_comb begin
        o_data_a = read_port(i_read_a);
    end

    always_comb begin
        o_data_b = read_port(i_read_b);
    end

endmodule

// ==== id_stage/control_unit.sv ====
`timescale 1ns/1ns
`include "id_config.svh"

module control_unit (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_enable,
    input  id_pkg::opcode_t     i_opcode,
    input  id_pkg::funct_t      i_funct,
    output id_pkg::ctrl_t       o_ctrl
);

    id_pkg::cu_state_t  state;
    id_pkg::cu_state_t  state_next;
    id_pkg::ctrl_t      ctrl_next;

    always_comb begin
        state_next = state;
        if ((state == id_pkg::CU_RUN) && (i_opcode == `OP_HALT)) begin
            state_next = id_pkg::CU_HALTED;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state <= id_pkg::CU_RUN;
        end else if (i_enable) begin
            state <= state_next;                // Only an accepted HALT counts
        end
    end

    // Opcode decode into the next control bundle
    always_comb begin
        ctrl_next        = '0;
        ctrl_next.alu_op = i_opcode;            // Non R-type passes the opcode
        if (state == id_pkg::CU_HALTED) begin
            ctrl_next     = '0;
            ctrl_next.hlt = 1'b1;               // Empty bundle, halt flag only
        end else begin
            case (i_opcode)
                `OP_RTYPE: begin
                    ctrl_next.alu_op    = i_funct;
                    ctrl_next.reg_dest  = 1'b1;
                    ctrl_next.reg_write = 1'b1;
                    if (i_funct == `FN_JR) begin
                        ctrl_next.jr_jalr   = 1'b1;
                        ctrl_next.reg_write = 1'b0;     // JR writes nothing back
                    end else if (i_funct == `FN_JALR) begin
                        ctrl_next.jr_jalr   = 1'b1;     // Link register written
                    end
                end
                `OP_LB, `OP_LH, `OP_LW: begin
                    ctrl_next.mem_read   = 1'b1;
                    ctrl_next.mem_to_reg = 1'b1;
                    ctrl_next.reg_write  = 1'b1;
                    ctrl_next.alu_src    = 1'b1;        // Base plus offset
                end
                `OP_SB, `OP_SH, `OP_SW: begin
                    ctrl_next.mem_write = 1'b1;
                    ctrl_next.alu_src   = 1'b1;
                end
                `OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI: begin
                    ctrl_next.alu_src   = 1'b1;
                    ctrl_next.reg_write = 1'b1;
                end
                `OP_BEQ, `OP_BNE: begin
                    ctrl_next.branch = 1'b1;
                end
                `OP_J: begin
                    ctrl_next.jump = 1'b1;
                end
                `OP_JAL: begin
                    ctrl_next.jump      = 1'b1;
                    ctrl_next.reg_write = 1'b1;         // Return address to r31
                end
                `OP_HALT: begin
                    // Same bundle as every load while halted
                    ctrl_next     = '0;
                    ctrl_next.hlt = 1'b1;
                end
                default: begin
                    ctrl_next = '0;                     // Unknown opcode
                end
            endcase

            // Memory access size
            case (i_opcode)
                `OP_LB, `OP_SB: begin
                    ctrl_next.byte_en = 1'b1;
                end
                `OP_LH, `OP_SH: begin
                    ctrl_next.halfword_en = 1'b1;
                end
                `OP_LW, `OP_SW: begin
                    ctrl_next.word_en = 1'b1;
                end
                default: begin
                    ctrl_next.word_en = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_ctrl <= '0;                       // Also the flush
        end else if (i_enable) begin
            o_ctrl <= ctrl_next;
        end
    end

endmodule

// ==== id_stage/operand_gen.sv ====
`timescale 1ns/1ns

module operand_gen (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_enable,
    input  id_pkg::inst_t       i_inst,
    input  id_pkg::pc_t         i_pc,
    input  id_pkg::data_t       i_data_a,
    input  id_pkg::data_t       i_data_b,
    output id_pkg::operands_t   o_ops
);

    id_pkg::operands_t ops_next;

    always_comb begin
        ops_next.data_a       = i_data_a;
        ops_next.data_b       = i_data_b;
        ops_next.immediate    = id_pkg::data_t'($signed(i_inst[15:0]));  // Sign-extended
        ops_next.shamt        = id_pkg::data_t'(i_inst[10:6]);           // Zero-extended
        ops_next.rt           = i_inst[20:16];
        ops_next.rd           = i_inst[15:11];
        ops_next.pc           = i_pc;
        // Region bits of the PC, target index, word aligned
        ops_next.jump_address = {i_pc[31:28], i_inst[25:0], 2'b00};
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_ops <= '0;
        end else if (i_enable) begin
            o_ops <= ops_next;                  // Same enable as the control bundle
        end
    end

endmodule

// ==== id_stage/id_stage.sv ====
`timescale 1ns/1ns

module id_stage (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_enable,           // Loads the ID/EX register
    input  id_pkg::inst_t       i_inst,
    input  id_pkg::pc_t         i_pc,
    input  id_pkg::wb_t         i_wb,               // From WB
    output id_pkg::ctrl_t       o_ctrl,             // To EX
    output id_pkg::operands_t   o_ops               // To EX
);

    id_pkg::data_t  data_a;                         // Unregistered rs value
    id_pkg::data_t  data_b;                         // Unregistered rt value

    register_bank register_bank_i (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_wb       (i_wb),
        .i_read_a   (i_inst[25:21]),                // rs
        .i_read_b   (i_inst[20:16]),                // rt
        .o_data_a   (data_a),
        .o_data_b   (data_b)
    );

    control_unit control_unit_i (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_enable   (i_enable),
        .i_opcode   (i_inst[31:26]),
        .i_funct    (i_inst[5:0]),
        .o_ctrl     (o_ctrl)
    );

    operand_gen operand_gen_i (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_enable   (i_enable),
        .i_inst     (i_inst),
        .i_pc       (i_pc),
        .i_data_a   (data_a),
        .i_data_b   (data_b),
        .o_ops      (o_ops)
    );

endmodule

// ==== testbench/id_stage_properties.sv ====
`timescale 1ns/1ns

module id_stage_properties (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_enable,
    input  id_pkg::ctrl_t       i_ctrl,
    input  id_pkg::operands_t   i_ops
);

    int unsigned fail_count = 0;            // Failed assertion count

    // Reset doubles as flush of the ID/EX register
    a_reset_clears: assert property (@(posedge i_clock)
        i_rst |=> ((i_ctrl == '0) && (i_ops == '0)))
        else begin
            fail_count++;
            $error("ID/EX register not cleared by reset");
        end

    a_mem_exclusive: assert property (@(posedge i_clock) disable iff (i_rst)
        !(i_ctrl.mem_read && i_ctrl.mem_write))
        else begin
            fail_count++;
            $error("mem_read and mem_write set together");
        end

    a_size_onehot: assert property (@(posedge i_clock) disable iff (i_rst)
        $onehot0({i_ctrl.byte_en, i_ctrl.halfword_en, i_ctrl.word_en}))
        else begin
            fail_count++;
            $error("More than one access size flag set");
        end

    a_hold_on_stall: assert property (@(posedge i_clock)
        (!i_enable && !i_rst) |=> ($stable(i_ctrl) && $stable(i_ops)))
        else begin
            fail_count++;
            $error("ID/EX register changed while enable was low");
        end

    a_halt_sticky: assert property (@(posedge i_clock)
        (i_ctrl.hlt && !i_rst) |=> i_ctrl.hlt)
        else begin
            fail_count++;
            $error("hlt dropped without a reset");
        end

endmodule

bind id_stage id_stage_properties props_i (
    .i_clock    (i_clock),
    .i_rst      (i_rst),
    .i_enable   (i_enable),
    .i_ctrl     (o_ctrl),
    .i_ops      (o_ops)
);

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/1ns
`include "id_config.svh"

module tb_id_stage;

    localparam int WATCHDOG_CYCLES = 5000;

    logic                   clock;
    logic                   rst;
    logic                   enable;
    id_pkg::inst_t          inst;
    id_pkg::pc_t            pc;
    id_pkg::wb_t            wb;
    id_pkg::ctrl_t          ctrl;
    id_pkg::operands_t      ops;

    id_pkg::data_t          model_regs [`ID_NUM_REGS];  // Register file model
    logic                   model_halted;
    id_pkg::ctrl_t          last_ctrl;                  // Last expected bundle, held by a stall
    id_pkg::operands_t      last_ops;
    int                     seed = 10250;
    int                     errors = 0;
    int                     checks = 0;

    id_stage dut_i (
        .i_clock    (clock),
        .i_rst      (rst),
        .i_enable   (enable),
        .i_inst     (inst),
        .i_pc       (pc),
        .i_wb       (wb),
        .o_ctrl     (ctrl),
        .o_ops      (ops)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
            @(posedge clock);
        end
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic id_pkg::inst_t r_type(input id_pkg::reg_addr_t rs,
                                             input id_pkg::reg_addr_t rt,
                                             input id_pkg::funct_t fn);
        return {`OP_RTYPE, rs, rt, 5'd3, 5'd0, fn};
    endfunction

    // Opcode and funct fixed, every other field random
    function automatic id_pkg::inst_t make_inst(input id_pkg::opcode_t op,
                                                input id_pkg::funct_t fn);
        logic [31:0] word;
        word = random_word();
        return {op, word[25:6], fn};
    endfunction

    function automatic id_pkg::wb_t write_port(input id_pkg::reg_addr_t addr,
                                               input id_pkg::data_t data);
        id_pkg::wb_t port;
        port.en   = 1'b1;
        port.addr = addr;
        port.data = data;
        return port;
    endfunction

    function automatic id_pkg::data_t model_read(input id_pkg::reg_addr_t addr,
                                                 input id_pkg::wb_t port);
        id_pkg::data_t value;
        value = model_regs[addr];
        if (port.en && (port.addr == addr)) begin
            value = port.data;                          // Same-cycle write wins
        end
        if (addr == 5'd0) begin
            value = '0;
        end
        return value;
    endfunction

    function automatic id_pkg::ctrl_t expected_ctrl(input id_pkg::inst_t word);
        id_pkg::ctrl_t      c;
        id_pkg::opcode_t    op;
        id_pkg::funct_t     fn;
        logic               is_r;
        logic               is_load;
        logic               is_store;
        logic               is_imm;
        op       = word[31:26];
        fn       = word[5:0];
        c        = '0;
        is_r     = (op == `OP_RTYPE);
        is_load  = (op == `OP_LB) || (op == `OP_LH) || (op == `OP_LW);
        is_store = (op == `OP_SB) || (op == `OP_SH) || (op == `OP_SW);
        is_imm   = (op == `OP_ADDI) || (op == `OP_SLTI) || (op == `OP_ANDI)
                   || (op == `OP_ORI) || (op == `OP_LUI);
        if (op == `OP_HALT) begin
            c.hlt = 1'b1;
        end else if (is_r || is_load || is_store || is_imm || (op == `OP_BEQ)
                     || (op == `OP_BNE) || (op == `OP_J) || (op == `OP_JAL)) begin
            c.alu_op      = is_r ? fn : op;
            c.reg_dest    = is_r;
            c.jr_jalr     = is_r && ((fn == `FN_JR) || (fn == `FN_JALR));
            c.reg_write   = (is_r && (fn != `FN_JR)) || is_load || is_imm || (op == `OP_JAL);
            c.mem_read    = is_load;
            c.mem_to_reg  = is_load;
            c.mem_write   = is_store;
            c.alu_src     = is_load || is_store || is_imm;
            c.branch      = (op == `OP_BEQ) || (op == `OP_BNE);
            c.jump        = (op == `OP_J) || (op == `OP_JAL);
            c.byte_en     = (op == `OP_LB) || (op == `OP_SB);
            c.halfword_en = (op == `OP_LH) || (op == `OP_SH);
            c.word_en     = (op == `OP_LW) || (op == `OP_SW);
        end
        return c;
    endfunction

    function automatic id_pkg::operands_t expected_ops(input id_pkg::inst_t word,
                                                       input id_pkg::pc_t pc_v,
                                                       input id_pkg::wb_t port);
        id_pkg::operands_t o;
        o.data_a       = model_read(word[25:21], port);
        o.data_b       = model_read(word[20:16], port);
        o.immediate    = {{16{word[15]}}, word[15:0]};
        o.shamt        = {27'd0, word[10:6]};
        o.rt           = word[20:16];
        o.rd           = word[15:11];
        o.pc           = pc_v;
        o.jump_address = {pc_v[31:28], word[25:0], 2'b00};
        return o;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_outputs(input id_pkg::ctrl_t exp_c, input id_pkg::operands_t exp_o);
        compare("o_ctrl", 32'(ctrl), 32'(exp_c));
        compare("o_ops.data_a", ops.data_a, exp_o.data_a);
        compare("o_ops.data_b", ops.data_b, exp_o.data_b);
        compare("o_ops.immediate", ops.immediate, exp_o.immediate);
        compare("o_ops.shamt", ops.shamt, exp_o.shamt);
        compare("o_ops.rt", 32'(ops.rt), 32'(exp_o.rt));
        compare("o_ops.rd", 32'(ops.rd), 32'(exp_o.rd));
        compare("o_ops.pc", ops.pc, exp_o.pc);
        compare("o_ops.jump_address", ops.jump_address, exp_o.jump_address);
    endtask

    task automatic apply_reset(input int cycles);
        rst    = 1'b1;
        enable = 1'b0;
        wb     = '0;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clock);
        end
        #1;
        rst = 1'b0;
        for (int r = 0; r < `ID_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        model_halted = 1'b0;
        last_ctrl    = '0;
        last_ops     = '0;
    endtask

    // One enabled load, checked one cycle later
    task automatic load_and_check(input id_pkg::inst_t inst_v, input id_pkg::pc_t pc_v,
                                  input id_pkg::wb_t wb_v);
        id_pkg::ctrl_t      exp_c;
        id_pkg::operands_t  exp_o;
        inst   = inst_v;
        pc     = pc_v;
        wb     = wb_v;
        enable = 1'b1;
        exp_c  = expected_ctrl(inst_v);
        if (model_halted) begin
            exp_c     = '0;
            exp_c.hlt = 1'b1;
        end
        exp_o = expected_ops(inst_v, pc_v, wb_v);
        @(posedge clock);
        #1;
        if (inst_v[31:26] == `OP_HALT) begin
            model_halted = 1'b1;
        end
        if (wb_v.en && (wb_v.addr != 5'd0)) begin
            model_regs[wb_v.addr] = wb_v.data;
        end
        enable    = 1'b0;
        wb.en     = 1'b0;
        last_ctrl = exp_c;
        last_ops  = exp_o;
        check_outputs(exp_c, exp_o);
    endtask

    task automatic stall_cycles(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            inst = random_word();                       // Must not reach the outputs
            pc   = random_word();
            @(posedge clock);
            #1;
            check_outputs(last_ctrl, last_ops);
        end
    endtask

    initial begin
        logic [31:0]        word;
        id_pkg::opcode_t    decode_list [16];
        rst    = 1'b1;
        enable = 1'b0;
        inst   = '0;
        pc     = '0;
        wb     = '0;
        decode_list = '{`OP_RTYPE, `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_ADDI, `OP_SLTI,
                        `OP_ANDI, `OP_ORI, `OP_LUI, `OP_LB, `OP_LH, `OP_LW, `OP_SB,
                        `OP_SH, `OP_SW};
        apply_reset(10);
        check_outputs('0, '0);

        // Fill every register, then read them back in random pairs
        for (int r = 1; r < `ID_NUM_REGS; r++) begin
            load_and_check(r_type(5'(r - 1), 5'(r), 6'h20), random_word(),
                           write_port(5'(r), random_word()));
        end
        for (int i = 0; i < 24; i++) begin
            word = random_word();
            load_and_check(r_type(word[4:0], word[9:5], 6'h20), random_word(), '0);
        end
        load_and_check(r_type(5'd0, 5'd0, 6'h20), random_word(), write_port(5'd0, 32'hdeadbeef));
        load_and_check(r_type(5'd7, 5'd9, 6'h21), random_word(), write_port(5'd7, random_word()));
        load_and_check(r_type(5'd7, 5'd0, 6'h21), random_word(), '0);

        // Decode table, plus JR, JALR and one unused opcode
        for (int i = 0; i < 16; i++) begin
            word = random_word();
            load_and_check(make_inst(decode_list[i], word[5:0]), random_word(), '0);
        end
        load_and_check(make_inst(`OP_RTYPE, `FN_JR), random_word(), '0);
        load_and_check(make_inst(`OP_RTYPE, `FN_JALR), random_word(), '0);
        load_and_check(make_inst(6'b010000, 6'h00), random_word(), '0);

        // Random instructions and PCs for the operand fields
        for (int i = 0; i < 40; i++) begin
            word = random_word();
            if (word[31:26] == `OP_HALT) begin
                word[31:26] = `OP_RTYPE;
            end
            load_and_check(word, random_word(), '0);
        end

        load_and_check(make_inst(`OP_LW, 6'h00), random_word(), '0);
        stall_cycles(6);

        // Halt is sticky until reset
        load_and_check(make_inst(`OP_HALT, 6'h00), random_word(), '0);
        for (int i = 0; i < 10; i++) begin
            load_and_check(random_word(), random_word(), '0);
        end
        stall_cycles(3);
        apply_reset(10);
        check_outputs('0, '0);
        load_and_check(make_inst(`OP_ADDI, 6'h00), random_word(), '0);
        load_and_check(make_inst(`OP_SW, 6'h00), random_word(), '0);

        $display("Checks: %0d, errors: %0d, property failures: %0d",
                 checks, errors, dut_i.props_i.fail_count);
        if ((errors == 0) && (dut_i.props_i.fail_count == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+common
common/id_pkg.sv
id_stage/register_bank.sv
id_stage/control_unit.sv
id_stage/operand_gen.sv
id_stage/id_stage.sv
testbench/id_stage_properties.sv
testbench/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
